//--- logic/rvDecodePkg.sv
package rvDecodePkg;

    // Lanes per bundle
    localparam int NUM_LANES = 2;

    // RV32I base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    // ALU control, low codes match the classic single-cycle set
    localparam logic [3:0] ALU_AND   = 4'b0000;
    localparam logic [3:0] ALU_OR    = 4'b0001;
    localparam logic [3:0] ALU_ADD   = 4'b0010;
    localparam logic [3:0] ALU_XOR   = 4'b0011;
    localparam logic [3:0] ALU_SLL   = 4'b0100;
    localparam logic [3:0] ALU_SRL   = 4'b0101;
    localparam logic [3:0] ALU_SUB   = 4'b0110;
    localparam logic [3:0] ALU_SLT   = 4'b0111;
    localparam logic [3:0] ALU_SLTU  = 4'b1000;
    localparam logic [3:0] ALU_SRA   = 4'b1001;
    // Operand B straight through, for LUI
    localparam logic [3:0] ALU_PASSB = 4'b1010;

    // One instruction word, read through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bFmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uFmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jFmt;
    } rvInstr;

endpackage

//--- logic/bundleLatch.sv
`timescale 1ns/10ps

module bundleLatch
    import rvDecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        bundleValid,
    input  logic [1:0]  slotValid,
    input  logic [31:0] instrIn [NUM_LANES],
    output logic [31:0] laneInstr [NUM_LANES],
    output logic        latchValid
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // Lanes idle on a NOP out of reset
            for (int k = 0; k < NUM_LANES; k++)
            begin
                laneInstr[k] <= NOP_WORD;
            end
            latchValid <= 1'b0;
        end
        else
        begin
            // Strobe delayed by one cycle
            latchValid <= bundleValid;
            if (bundleValid)
            begin
                for (int k = 0; k < NUM_LANES; k++)
                begin
                    // Empty slot becomes a NOP
                    laneInstr[k] <= slotValid[k] ? instrIn[k] : NOP_WORD;
                end
            end
        end
    end

    // A strobe carries at least one real instruction
    assert property (@(posedge clk) disable iff (rst)
        bundleValid |-> (slotValid != 2'b00));

endmodule

//--- logic/immGen.sv
`timescale 1ns/10ps

module immGen
    import rvDecodePkg::*;
(
    input  rvInstr      instr,
    output logic [31:0] imm
);

    always_comb
    begin
        imm = '0;
        case (instr.rFmt.opcode)
            // I-type, plain sign extension
            OP_LOAD, OP_JALR, OP_SYSTEM:
            begin
                imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            end
            OP_IMM:
            begin
                // SLLI, SRLI, SRAI keep shamt only
                if (instr.iFmt.funct3 == 3'b001 || instr.iFmt.funct3 == 3'b101)
                begin
                    imm = {27'b0, instr.rFmt.rs2};
                end
                else
                begin
                    imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
                end
            end
            // S-type, offset split around rs1/rs2
            OP_STORE:
            begin
                imm = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            end
            // B-type, bit 0 always zero
            OP_BRANCH:
            begin
                imm = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
                       instr.bFmt.imm10to5, instr.bFmt.imm4to1, 1'b0};
            end
            // J-type, 21-bit offset
            OP_JAL:
            begin
                imm = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.imm19to12,
                       instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
            end
            // U-type, upper 20 bits at the top
            OP_LUI, OP_AUIPC:
            begin
                imm = {instr.uFmt.imm, 12'b0};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- logic/decodeLane.sv
`timescale 1ns/10ps

module decodeLane
    import rvDecodePkg::*;
(
    input  logic [31:0] instr,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [31:0] imm,
    output logic [3:0]  aluControl,
    output logic        aluSrc,
    output logic        memRead,
    output logic        memWrite,
    output logic        regWrite,
    output logic        memToReg,
    output logic        branch,
    output logic        jump,
    output logic        illegal
);

    rvInstr word;
    logic   funct7Ok;

    // funct3 to ALU code, alt selects SUB and SRA
    function automatic logic [3:0] aluFromFunct(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign word = instr;

    // Register fields sit at the same spot in every format
    assign rd  = word.rFmt.rd;
    assign rs1 = word.rFmt.rs1;
    assign rs2 = word.rFmt.rs2;

    immGen immGenInst (
        .instr(word),
        .imm  (imm)
    );

    // R-type: funct7 zero, or 0100000 only for SUB and SRA
    assign funct7Ok = (word.rFmt.funct7 == 7'b0000000) ||
                      ((word.rFmt.funct7 == 7'b0100000) &&
                       (word.rFmt.funct3 == 3'b000 || word.rFmt.funct3 == 3'b101));

    always_comb
    begin
        aluControl = ALU_AND;
        aluSrc     = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        regWrite   = 1'b0;
        memToReg   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        illegal    = 1'b0;
        case (word.rFmt.opcode)
            OP_LUI:
            begin
                aluControl = ALU_PASSB;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
            end
            OP_AUIPC:
            begin
                aluControl = ALU_ADD;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
            end
            // Link register written with the return address
            OP_JAL, OP_JALR:
            begin
                aluControl = ALU_ADD;
                aluSrc     = 1'b1;
                jump       = 1'b1;
                regWrite   = 1'b1;
            end
            // Compare by subtraction
            OP_BRANCH:
            begin
                aluControl = ALU_SUB;
                branch     = 1'b1;
            end
            // Address = rs1 + offset
            OP_LOAD:
            begin
                aluControl = ALU_ADD;
                aluSrc     = 1'b1;
                memRead    = 1'b1;
                memToReg   = 1'b1;
                regWrite   = 1'b1;
            end
            OP_STORE:
            begin
                aluControl = ALU_ADD;
                aluSrc     = 1'b1;
                memWrite   = 1'b1;
            end
            // No SUBI, bit 30 only matters for SRAI
            OP_IMM:
            begin
                aluControl = aluFromFunct(word.iFmt.funct3,
                                          (word.iFmt.funct3 == 3'b101) && instr[30]);
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
            end
            OP_REG:
            begin
                if (funct7Ok)
                begin
                    aluControl = aluFromFunct(word.rFmt.funct3, word.rFmt.funct7[5]);
                    regWrite   = 1'b1;
                end
                else
                begin
                    illegal = 1'b1;
                end
            end
            // ECALL, EBREAK pass as no-ops
            OP_SYSTEM:
            begin
                illegal = 1'b0;
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

    // Never both memory directions for one opcode
    assert final (!(memRead && memWrite));

endmodule

//--- logic/issueCollector.sv
`timescale 1ns/10ps

module issueCollector
    import rvDecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        latchValid,
    input  logic [4:0]  laneRd [NUM_LANES],
    input  logic [4:0]  laneRs1 [NUM_LANES],
    input  logic [4:0]  laneRs2 [NUM_LANES],
    input  logic [31:0] laneImm [NUM_LANES],
    input  logic [3:0]  laneAluControl [NUM_LANES],
    input  logic        laneAluSrc [NUM_LANES],
    input  logic        laneMemRead [NUM_LANES],
    input  logic        laneMemWrite [NUM_LANES],
    input  logic        laneRegWrite [NUM_LANES],
    input  logic        laneMemToReg [NUM_LANES],
    input  logic        laneBranch [NUM_LANES],
    input  logic        laneJump [NUM_LANES],
    input  logic        laneIllegal [NUM_LANES],
    output logic [4:0]  outRd [NUM_LANES],
    output logic [4:0]  outRs1 [NUM_LANES],
    output logic [4:0]  outRs2 [NUM_LANES],
    output logic [31:0] outImm [NUM_LANES],
    output logic [3:0]  outAluControl [NUM_LANES],
    output logic        outAluSrc [NUM_LANES],
    output logic        outMemRead [NUM_LANES],
    output logic        outMemWrite [NUM_LANES],
    output logic        outRegWrite [NUM_LANES],
    output logic        outMemToReg [NUM_LANES],
    output logic        outBranch [NUM_LANES],
    output logic        outJump [NUM_LANES],
    output logic        outIllegal [NUM_LANES],
    output logic        outValid,
    output logic        hazard
);

    logic hazardNext;

    // Lane 1 reads what lane 0 writes in the same bundle; x0 never counts
    assign hazardNext = laneRegWrite[0] && (laneRd[0] != 5'd0) && !laneIllegal[1] &&
                        ((laneRd[0] == laneRs1[1]) || (laneRd[0] == laneRs2[1]));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            hazard   <= 1'b0;
            for (int k = 0; k < NUM_LANES; k++)
            begin
                outRd[k]         <= '0;
                outRs1[k]        <= '0;
                outRs2[k]        <= '0;
                outImm[k]        <= '0;
                outAluControl[k] <= '0;
                outAluSrc[k]     <= 1'b0;
                outMemRead[k]    <= 1'b0;
                outMemWrite[k]   <= 1'b0;
                outRegWrite[k]   <= 1'b0;
                outMemToReg[k]   <= 1'b0;
                outBranch[k]     <= 1'b0;
                outJump[k]       <= 1'b0;
                outIllegal[k]    <= 1'b0;
            end
        end
        else
        begin
            outValid <= latchValid;
            // Results held until the next bundle
            if (latchValid)
            begin
                hazard <= hazardNext;
                for (int k = 0; k < NUM_LANES; k++)
                begin
                    outRd[k]         <= laneRd[k];
                    outRs1[k]        <= laneRs1[k];
                    outRs2[k]        <= laneRs2[k];
                    outImm[k]        <= laneImm[k];
                    outAluControl[k] <= laneAluControl[k];
                    outAluSrc[k]     <= laneAluSrc[k];
                    outMemRead[k]    <= laneMemRead[k];
                    outMemWrite[k]   <= laneMemWrite[k];
                    outRegWrite[k]   <= laneRegWrite[k];
                    outMemToReg[k]   <= laneMemToReg[k];
                    outBranch[k]     <= laneBranch[k];
                    outJump[k]       <= laneJump[k];
                    outIllegal[k]    <= laneIllegal[k];
                end
            end
        end
    end

    // Lane decode plus capture never let an illegal word write a register
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : gIllegalChk
        assert property (@(posedge clk) disable iff (rst)
            outValid |-> !(outIllegal[k] && outRegWrite[k]));
    end

endmodule

//--- logic/rv32iDecodeTop.sv
`timescale 1ns/10ps

module rv32iDecodeTop
    import rvDecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        bundleValid,
    input  logic [1:0]  slotValid,
    input  logic [31:0] instrIn [NUM_LANES],
    output logic [4:0]  outRd [NUM_LANES],
    output logic [4:0]  outRs1 [NUM_LANES],
    output logic [4:0]  outRs2 [NUM_LANES],
    output logic [31:0] outImm [NUM_LANES],
    output logic [3:0]  outAluControl [NUM_LANES],
    output logic        outAluSrc [NUM_LANES],
    output logic        outMemRead [NUM_LANES],
    output logic        outMemWrite [NUM_LANES],
    output logic        outRegWrite [NUM_LANES],
    output logic        outMemToReg [NUM_LANES],
    output logic        outBranch [NUM_LANES],
    output logic        outJump [NUM_LANES],
    output logic        outIllegal [NUM_LANES],
    output logic        outValid,
    output logic        hazard
);

    // Latched words and their strobe
    logic [31:0] laneInstr [NUM_LANES];
    logic        latchValid;

    // Combinational decode results per lane
    logic [4:0]  laneRd [NUM_LANES];
    logic [4:0]  laneRs1 [NUM_LANES];
    logic [4:0]  laneRs2 [NUM_LANES];
    logic [31:0] laneImm [NUM_LANES];
    logic [3:0]  laneAluControl [NUM_LANES];
    logic        laneAluSrc [NUM_LANES];
    logic        laneMemRead [NUM_LANES];
    logic        laneMemWrite [NUM_LANES];
    logic        laneRegWrite [NUM_LANES];
    logic        laneMemToReg [NUM_LANES];
    logic        laneBranch [NUM_LANES];
    logic        laneJump [NUM_LANES];
    logic        laneIllegal [NUM_LANES];

    bundleLatch bundleLatchInst (
        .clk        (clk),
        .rst        (rst),
        .bundleValid(bundleValid),
        .slotValid  (slotValid),
        .instrIn    (instrIn),
        .laneInstr  (laneInstr),
        .latchValid (latchValid)
    );

    // One decoder per slot
    for (genvar k = 0; k < NUM_LANES; k++)
    begin : gLane
        decodeLane decodeLaneInst (
            .instr     (laneInstr[k]),
            .rd        (laneRd[k]),
            .rs1       (laneRs1[k]),
            .rs2       (laneRs2[k]),
            .imm       (laneImm[k]),
            .aluControl(laneAluControl[k]),
            .aluSrc    (laneAluSrc[k]),
            .memRead   (laneMemRead[k]),
            .memWrite  (laneMemWrite[k]),
            .regWrite  (laneRegWrite[k]),
            .memToReg  (laneMemToReg[k]),
            .branch    (laneBranch[k]),
            .jump      (laneJump[k]),
            .illegal   (laneIllegal[k])
        );
    end

    issueCollector issueCollectorInst (
        .clk           (clk),
        .rst           (rst),
        .latchValid    (latchValid),
        .laneRd        (laneRd),
        .laneRs1       (laneRs1),
        .laneRs2       (laneRs2),
        .laneImm       (laneImm),
        .laneAluControl(laneAluControl),
        .laneAluSrc    (laneAluSrc),
        .laneMemRead   (laneMemRead),
        .laneMemWrite  (laneMemWrite),
        .laneRegWrite  (laneRegWrite),
        .laneMemToReg  (laneMemToReg),
        .laneBranch    (laneBranch),
        .laneJump      (laneJump),
        .laneIllegal   (laneIllegal),
        .outRd         (outRd),
        .outRs1        (outRs1),
        .outRs2        (outRs2),
        .outImm        (outImm),
        .outAluControl (outAluControl),
        .outAluSrc     (outAluSrc),
        .outMemRead    (outMemRead),
        .outMemWrite   (outMemWrite),
        .outRegWrite   (outRegWrite),
        .outMemToReg   (outMemToReg),
        .outBranch     (outBranch),
        .outJump       (outJump),
        .outIllegal    (outIllegal),
        .outValid      (outValid),
        .hazard        (hazard)
    );

endmodule

//--- testbench/decodeTb.sv
`timescale 1ns/10ps

module decodeTb
    import rvDecodePkg::*;
();

    logic        clk;
    logic        rst;
    logic        bundleValid;
    logic [1:0]  slotValid;
    logic [31:0] instrIn [NUM_LANES];
    logic [4:0]  outRd [NUM_LANES];
    logic [4:0]  outRs1 [NUM_LANES];
    logic [4:0]  outRs2 [NUM_LANES];
    logic [31:0] outImm [NUM_LANES];
    logic [3:0]  outAluControl [NUM_LANES];
    logic        outAluSrc [NUM_LANES];
    logic        outMemRead [NUM_LANES];
    logic        outMemWrite [NUM_LANES];
    logic        outRegWrite [NUM_LANES];
    logic        outMemToReg [NUM_LANES];
    logic        outBranch [NUM_LANES];
    logic        outJump [NUM_LANES];
    logic        outIllegal [NUM_LANES];
    logic        outValid;
    logic        hazard;

    // One record per golden line, column n in bits 32n+31..32n
    logic [447:0] golden [$];
    // Cycle in which each bundle was driven
    int           sendCycle [$];
    int           cycles;
    int           cycleLimit;
    int           txCount;
    int           rxCount;
    int           checkCount;
    int           errorCount;
    int           testsRun;
    int           testsFailed;
    int           errBefore;

    rv32iDecodeTop dut (
        .clk(clk), .rst(rst), .bundleValid(bundleValid), .slotValid(slotValid),
        .instrIn(instrIn), .outRd(outRd), .outRs1(outRs1), .outRs2(outRs2),
        .outImm(outImm), .outAluControl(outAluControl), .outAluSrc(outAluSrc),
        .outMemRead(outMemRead), .outMemWrite(outMemWrite), .outRegWrite(outRegWrite),
        .outMemToReg(outMemToReg), .outBranch(outBranch), .outJump(outJump),
        .outIllegal(outIllegal), .outValid(outValid), .hazard(hazard)
    );

    function automatic logic [31:0] column(input logic [447:0] rec, input int n);
        return rec[32*n +: 32];
    endfunction

    // Control levels of one lane in golden column order
    function automatic logic [31:0] ctrlWord(input int k);
        return {20'b0, outIllegal[k], outJump[k], outBranch[k], outMemToReg[k],
                outRegWrite[k], outMemWrite[k], outMemRead[k], outAluSrc[k], outAluControl[k]};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        if (got !== want)
        begin
            errorCount++;
            $display("ERR %t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        testsRun++;
        if (errorCount != errStart)
        begin
            testsFailed++;
            $display("test %0d %s: FAIL", testsRun, name);
        end
        else
        begin
            $display("test %0d %s: ok", testsRun, name);
        end
    endtask

    // Comment lines and blanks give no hex match and drop out
    task automatic loadGolden();
        int fd;
        int n;
        logic [8*256-1:0] lineBuf;
        logic [31:0] slot, w0, w1, ctl0, rd0, ra0, rb0, imm0;
        logic [31:0] ctl1, rd1, ra1, rb1, imm1, haz;
        fd = $fopen("testbench/decodeGolden.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open golden file testbench/decodeGolden.txt");
            return;
        end
        while (!$feof(fd))
        begin
            lineBuf = '0;
            n = $fgets(lineBuf, fd);
            if (n > 0)
            begin
                n = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            slot, w0, w1, ctl0, rd0, ra0, rb0, imm0,
                            ctl1, rd1, ra1, rb1, imm1, haz);
                if (n == 14)
                begin
                    golden.push_back({haz, imm1, rb1, ra1, rd1, ctl1, imm0, rb0, ra0, rd0,
                                      ctl0, w1, w0, slot});
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic compareBundle(input int idx);
        logic [447:0] rec;
        int errStart;
        rec = golden[idx];
        errStart = errorCount;
        // Strobe in cycle c shows up as outValid in cycle c+2
        checkValue($sformatf("line %0d latency", idx), cycles, sendCycle[idx] + 2);
        for (int k = 0; k < NUM_LANES; k++)
        begin
            checkValue($sformatf("line %0d lane %0d ctrl", idx, k), ctrlWord(k),
                       column(rec, 3 + 5*k));
            checkValue($sformatf("line %0d lane %0d rd", idx, k), 32'(outRd[k]),
                       column(rec, 4 + 5*k));
            checkValue($sformatf("line %0d lane %0d rs1", idx, k), 32'(outRs1[k]),
                       column(rec, 5 + 5*k));
            checkValue($sformatf("line %0d lane %0d rs2", idx, k), 32'(outRs2[k]),
                       column(rec, 6 + 5*k));
            checkValue($sformatf("line %0d lane %0d imm", idx, k), outImm[k],
                       column(rec, 7 + 5*k));
        end
        checkValue($sformatf("line %0d hazard", idx), 32'(hazard), column(rec, 13));
        finishTest($sformatf("golden line %0d", idx), errStart);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle count and watchdog
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, outputs still missing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Outputs settle after posedge, sampled on the falling edge
    always @(negedge clk)
    begin
        if (!rst && outValid)
        begin
            if (rxCount >= txCount)
            begin
                errorCount++;
                $display("outValid pulsed at %t with no bundle in flight", $time);
            end
            else
            begin
                compareBundle(rxCount);
                rxCount++;
            end
        end
    end

    initial
    begin
        $timeformat(-9, 1, " ns", 0);
        rst         = 1'b1;
        bundleValid = 1'b0;
        slotValid   = 2'b00;
        instrIn[0]  = '0;
        instrIn[1]  = '0;
        cycles      = 0;
        txCount     = 0;
        rxCount     = 0;
        checkCount  = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        cycleLimit  = 1000;
        loadGolden();
        // Lines, reset, then margin for idle and latency
        cycleLimit = golden.size() + 16 + 20;
        if (golden.size() == 0)
        begin
            errorCount++;
            $display("No usable lines in the golden file");
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet after reset, nothing strobed
        errBefore = errorCount;
        checkValue("hazard after reset", 32'(hazard), 32'h0);
        for (int k = 0; k < NUM_LANES; k++)
        begin
            checkValue($sformatf("lane %0d ctrl after reset", k), ctrlWord(k), 32'h0);
            checkValue($sformatf("lane %0d imm after reset", k), outImm[k], 32'h0);
        end
        repeat (4)
        begin
            checkValue("outValid while idle", 32'(outValid), 32'h0);
            @(negedge clk);
        end
        finishTest("reset and idle", errBefore);

        // Back-to-back bundles, one per cycle
        for (int i = 0; i < golden.size(); i++)
        begin
            slotValid   = golden[i][1:0];
            instrIn[0]  = column(golden[i], 1);
            instrIn[1]  = column(golden[i], 2);
            bundleValid = 1'b1;
            sendCycle.push_back(cycles);
            txCount = i + 1;
            @(negedge clk);
        end
        bundleValid = 1'b0;
        slotValid   = 2'b00;

        wait (rxCount == golden.size());
        repeat (2) @(negedge clk);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rv32iDecodeTop.f
logic/rvDecodePkg.sv
logic/bundleLatch.sv
logic/immGen.sv
logic/decodeLane.sv
logic/issueCollector.sv
logic/rv32iDecodeTop.sv
testbench/decodeTb.sv

//--- testbench/decodeGolden.txt
# slot instr0 instr1 | lane0: ctrl rd rs1 rs2 imm | lane1: ctrl rd rs1 rs2 imm | hazard
# ctrl = {illegal jump branch memToReg regWrite memWrite memRead aluSrc, aluControl[3:0]}
3 123452B7 FFFFF317 09A 05 08 03 12345000 092 06 1F 1F FFFFF000 0
3 FF9FF0EF 00408067 492 01 1F 19 FFFFFFF8 492 00 01 04 00000004 1
3 00310863 FE521EE3 206 10 02 03 00000010 206 1D 04 05 FFFFFFFC 0
3 FF442383 7FF3C483 1B2 07 08 14 FFFFFFF4 1B2 09 07 1F 000007FF 1
3 FEA5A623 00A606B3 052 0C 0B 0A FFFFFFEC 082 0D 0C 0A 00000000 0
3 001102A3 04321023 052 05 02 01 00000005 052 00 04 03 00000040 0
3 FFF78713 8008A813 092 0E 0F 1F FFFFFFFF 097 10 11 00 FFFFF800 0
3 0649B913 555ACA13 098 12 13 04 00000064 093 14 15 15 00000555 0
3 F00BEB13 0FFB7C13 091 16 17 00 FFFFFF00 090 18 16 1F 000000FF 1
3 01FD1C93 407E5D93 094 19 1A 1F 0000001F 099 1B 1C 07 00000007 0
3 00CF5E93 7FF00F93 095 1D 1E 0C 0000000C 092 1F 00 1F 000007FF 0
3 003100B3 40508233 082 01 02 03 00000000 086 04 01 05 00000000 1
3 00839333 006524B3 084 06 07 08 00000000 087 09 0A 06 00000000 1
3 00D635B3 0107C733 088 0B 0C 0D 00000000 083 0E 0F 10 00000000 0
3 013958B3 416ADA33 085 11 12 13 00000000 089 14 15 16 00000000 0
3 019C6BB3 017DFD33 081 17 18 19 00000000 080 1A 1B 17 00000000 1
3 00208033 000001B3 082 00 01 02 00000000 082 03 00 00 00000000 0
3 00000073 00100073 000 00 00 00 00000000 000 00 00 01 00000001 0
3 FFFFFFFF 00000000 800 1F 1F 1F 00000000 800 00 00 00 00000000 0
3 023100B3 40429333 800 01 02 03 00000000 800 06 05 04 00000000 0
3 00100293 02728333 092 05 00 01 00000001 800 06 05 07 00000000 0
1 800002B7 DEADBEEF 09A 05 00 00 80000000 092 00 00 00 00000000 0
2 12345678 00001117 092 00 00 00 00000000 092 02 00 00 00001000 0
3 0020E0E3 7FFFF06F 206 01 01 02 00000800 492 00 1F 1F 000FFFFE 0
3 800100E7 0011A423 492 01 02 00 FFFFF800 052 08 03 01 00000008 1
